/* verilog/ipif_pkg.sv */
`default_nettype none

// Bus side of the register interface.
// Chip-enable layout and register reset values.
package ipif_pkg;

    // Width of the bus data lines
    localparam int BUS_DATA_W = 32;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // One chip-enable bit per register for writes and for reads
    localparam int N_REG = 4;
    typedef logic [N_REG-1:0] reg_ce_t;

    // Chip-enable bit positions
    // Bit 3 has no register behind it
    localparam int REG_OUTPUT_SELECT = 0;
    localparam int REG_N_IDLE_WORDS  = 1;
    localparam int REG_IDLE_WORD     = 2;

    // Values after reset
    localparam logic [3:0]  RST_OUTPUT_SELECT = 4'd0;
    localparam logic [15:0] RST_N_IDLE_WORDS  = 16'd256;
    localparam bus_data_t   RST_IDLE_WORD     = 32'haccccccc;

endpackage

`default_nettype wire

/* verilog/stream_pkg.sv */
`default_nettype none

// Datapath side.
// Stream word, channel count and the filler state machine.
package stream_pkg;

    // One stream word
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] data_word_t;

    // Input channels behind the mux
    localparam int NUM_CH = 4;

    // Source select wide enough to hold out-of-range values
    localparam int SEL_W = 4;
    typedef logic [SEL_W-1:0] out_sel_t;

    // Length of an idle run
    localparam int IDLE_CNT_W = 16;
    typedef logic [IDLE_CNT_W-1:0] idle_cnt_t;

    // FILL sends idle words, PASS forwards the selected channel
    typedef enum logic
    {
        FILL,
        PASS
    } filler_state_t;

endpackage

`default_nettype wire

/* verilog/ipif_param_decode.sv */
`default_nettype none

module ipif_param_decode
    import ipif_pkg::*;
    import stream_pkg::*;
(
    input  wire             clk,
    input  wire             IPIF_bus2ip_resetn,

    // Register bus
    input  wire bus_data_t  bus2ip_data,
    input  wire reg_ce_t    bus2ip_wrce,
    input  wire reg_ce_t    bus2ip_rdce,
    output bus_data_t       ip2bus_data,
    output logic            ip2bus_rdack,
    output logic            ip2bus_wrack,

    // Settings towards the datapath
    output out_sel_t        output_select,
    output idle_cnt_t       n_idle_words,
    output data_word_t      idle_word
);

    logic       wr_output_select;
    logic       wr_n_idle_words;
    logic       wr_idle_word;
    logic       rd_output_select;
    logic       rd_n_idle_words;
    logic       rd_idle_word;
    bus_data_t  read_word;

    ////////////////////////////////////////////////////////////////////////////
    // Chip-enable decode
    ////////////////////////////////////////////////////////////////////////////

    // Only a single set bit selects a register
    assign wr_output_select = (bus2ip_wrce == reg_ce_t'(1 << REG_OUTPUT_SELECT));
    assign wr_n_idle_words  = (bus2ip_wrce == reg_ce_t'(1 << REG_N_IDLE_WORDS));
    assign wr_idle_word     = (bus2ip_wrce == reg_ce_t'(1 << REG_IDLE_WORD));

    assign rd_output_select = (bus2ip_rdce == reg_ce_t'(1 << REG_OUTPUT_SELECT));
    assign rd_n_idle_words  = (bus2ip_rdce == reg_ce_t'(1 << REG_N_IDLE_WORDS));
    assign rd_idle_word     = (bus2ip_rdce == reg_ce_t'(1 << REG_IDLE_WORD));

    ////////////////////////////////////////////////////////////////////////////
    // Settings
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
        begin
            output_select <= RST_OUTPUT_SELECT;
            n_idle_words  <= RST_N_IDLE_WORDS;
            idle_word     <= RST_IDLE_WORD;
        end
        else
        begin
            // Each setting takes the low bits of the bus word
            if (wr_output_select)
                output_select <= out_sel_t'(bus2ip_data);
            if (wr_n_idle_words)
                n_idle_words <= idle_cnt_t'(bus2ip_data);
            if (wr_idle_word)
                idle_word <= data_word_t'(bus2ip_data);
        end
    end

    // Any write strobe is acknowledged, mapped or not
    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
            ip2bus_wrack <= 1'b0;
        else
            ip2bus_wrack <= |bus2ip_wrce;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////////////////////

    // Reads see the value before a write in the same cycle
    always_comb
    begin
        read_word = '0;
        if (rd_output_select)
            read_word = bus_data_t'(output_select);
        if (rd_n_idle_words)
            read_word = bus_data_t'(n_idle_words);
        if (rd_idle_word)
            read_word = bus_data_t'(idle_word);
    end

    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
        begin
            ip2bus_data  <= '0;
            ip2bus_rdack <= 1'b0;
        end
        else
        begin
            ip2bus_data  <= read_word;
            ip2bus_rdack <= |bus2ip_rdce;
        end
    end

endmodule

`default_nettype wire

/* verilog/channel_mux.sv */
`default_nettype none

module channel_mux
    import stream_pkg::*;
(
    input  wire                          clk,
    input  wire                          IPIF_bus2ip_resetn,

    input  wire out_sel_t                output_select,

    // Input channels
    input  wire data_word_t [NUM_CH-1:0] ch_data,
    input  wire [NUM_CH-1:0]             ch_valid,

    // Selected channel through one register stage
    output data_word_t                   mux_data,
    output logic                         mux_valid
);

    data_word_t sel_data;
    logic       sel_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Channel select
    ////////////////////////////////////////////////////////////////////////////

    // Compare against every channel index so that a select of NUM_CH or
    // more matches nothing and the valid stays low
    always_comb
    begin
        sel_data  = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < NUM_CH; i++)
        begin
            if (output_select == out_sel_t'(i))
            begin
                sel_data  = ch_data[i];
                sel_valid = ch_valid[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
            mux_valid <= 1'b0;
        else
            mux_valid <= sel_valid;
    end

    // Word follows the valid
    always_ff @(posedge clk)
    begin
        mux_data <= sel_data;
    end

endmodule

`default_nettype wire

/* verilog/idle_filler.sv */
`default_nettype none

module idle_filler
    import stream_pkg::*;
(
    input  wire              clk,
    input  wire              IPIF_bus2ip_resetn,

    // Settings
    input  wire out_sel_t    output_select,
    input  wire idle_cnt_t   n_idle_words,
    input  wire data_word_t  idle_word,

    // From the channel mux
    input  wire data_word_t  mux_data,
    input  wire              mux_valid,

    // Output stream
    output data_word_t       out_data,
    output logic             out_valid,
    output logic             out_idle
);

    filler_state_t  state;
    filler_state_t  state_nxt;
    filler_state_t  eff_state;
    idle_cnt_t      cnt;
    idle_cnt_t      cnt_nxt;
    idle_cnt_t      eff_cnt;
    out_sel_t       sel_q;
    logic           restart_q;
    logic           sel_change;

    ////////////////////////////////////////////////////////////////////////////
    // Run start
    ////////////////////////////////////////////////////////////////////////////

    // restart_q forces a run on the first edge after reset, so the
    // count comes from the register block at its reset value
    assign sel_change = restart_q || (output_select != sel_q);

    // A new run starts in the same cycle the change is seen.
    // The count is only sampled here and later count writes wait for the
    // next run
    always_comb
    begin
        eff_state = state;
        eff_cnt   = cnt;
        if (sel_change)
        begin
            eff_cnt   = n_idle_words;
            eff_state = (n_idle_words == '0) ? PASS : FILL;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    // cnt holds the idle words still to send, including this cycle's
    always_comb
    begin
        state_nxt = eff_state;
        cnt_nxt   = eff_cnt;
        if (eff_state == FILL)
        begin
            cnt_nxt = eff_cnt - idle_cnt_t'(1);
            if (eff_cnt == idle_cnt_t'(1))
                state_nxt = PASS;
        end
    end

    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
        begin
            state     <= FILL;
            cnt       <= '0;
            sel_q     <= '0;
            restart_q <= 1'b1;
        end
        else
        begin
            state     <= state_nxt;
            cnt       <= cnt_nxt;
            sel_q     <= output_select;
            restart_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////////////////////

    // Mux words arriving during FILL are simply not forwarded
    always_ff @(posedge clk or negedge IPIF_bus2ip_resetn)
    begin
        if (!IPIF_bus2ip_resetn)
        begin
            out_valid <= 1'b0;
            out_idle  <= 1'b0;
        end
        else if (eff_state == FILL)
        begin
            out_valid <= 1'b1;
            out_idle  <= 1'b1;
        end
        else
        begin
            out_valid <= mux_valid;
            out_idle  <= 1'b0;
        end
    end

    // Idle word is taken live from the register block
    always_ff @(posedge clk)
    begin
        if (eff_state == FILL)
            out_data <= idle_word;
        else
            out_data <= mux_data;
    end

endmodule

`default_nettype wire

/* verilog/stream_output_top.sv */
`default_nettype none

module stream_output_top
    import ipif_pkg::*;
    import stream_pkg::*;
(
    input  wire                          clk,
    input  wire                          IPIF_bus2ip_resetn,

    // Register bus
    input  wire bus_data_t               bus2ip_data,
    input  wire reg_ce_t                 bus2ip_wrce,
    input  wire reg_ce_t                 bus2ip_rdce,
    output bus_data_t                    ip2bus_data,
    output logic                         ip2bus_rdack,
    output logic                         ip2bus_wrack,

    // Input channels
    input  wire data_word_t [NUM_CH-1:0] ch_data,
    input  wire [NUM_CH-1:0]             ch_valid,

    // Output stream
    output data_word_t                   out_data,
    output logic                         out_valid,
    output logic                         out_idle
);

    // Settings from the register block
    out_sel_t   output_select;
    idle_cnt_t  n_idle_words;
    data_word_t idle_word;

    // Selected channel
    data_word_t mux_data;
    logic       mux_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Register block
    ////////////////////////////////////////////////////////////////////////////

    ipif_param_decode u_ipif_param_decode (
        .clk                (clk),
        .IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
        .bus2ip_data        (bus2ip_data),
        .bus2ip_wrce        (bus2ip_wrce),
        .bus2ip_rdce        (bus2ip_rdce),
        .ip2bus_data        (ip2bus_data),
        .ip2bus_rdack       (ip2bus_rdack),
        .ip2bus_wrack       (ip2bus_wrack),
        .output_select      (output_select),
        .n_idle_words       (n_idle_words),
        .idle_word          (idle_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    channel_mux u_channel_mux (
        .clk                (clk),
        .IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
        .output_select      (output_select),
        .ch_data            (ch_data),
        .ch_valid           (ch_valid),
        .mux_data           (mux_data),
        .mux_valid          (mux_valid)
    );

    idle_filler u_idle_filler (
        .clk                (clk),
        .IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
        .output_select      (output_select),
        .n_idle_words       (n_idle_words),
        .idle_word          (idle_word),
        .mux_data           (mux_data),
        .mux_valid          (mux_valid),
        .out_data           (out_data),
        .out_valid          (out_valid),
        .out_idle           (out_idle)
    );

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare tasks, one per result type
// A mismatch prints an error line and ends the run

task automatic check_word(input string name, input data_word_t actual,
                          input data_word_t expected);
begin
    if (actual !== expected)
    begin
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
begin
    if (actual !== expected)
    begin
        $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
        abort_run();
    end
end
endtask

task automatic check_bus(input string name, input bus_data_t actual,
                         input bus_data_t expected);
begin
    if (actual !== expected)
    begin
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
end
endtask

// Lengths of idle runs
task automatic check_count(input string name, input idle_cnt_t actual,
                           input idle_cnt_t expected);
begin
    if (actual !== expected)
    begin
        $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        abort_run();
    end
end
endtask

`endif

/* tests/tb_stream_output.sv */
`default_nettype none

module tb_stream_output
    import ipif_pkg::*;
    import stream_pkg::*;
();

    localparam int unsigned SEED = 32'hb729_e7ec;
    localparam reg_ce_t CE_SEL   = reg_ce_t'(1 << REG_OUTPUT_SELECT);
    localparam reg_ce_t CE_NIDLE = reg_ce_t'(1 << REG_N_IDLE_WORDS);
    localparam reg_ce_t CE_IDLE  = reg_ce_t'(1 << REG_IDLE_WORD);
    localparam int N_OOR_SEL     = (1 << SEL_W) - NUM_CH;

    // Phase lengths in cycles
    localparam int RESET_CYCLES = 5;
    localparam int N_RAND_OPS   = 60;
    localparam int SETTLE       = 20;
    localparam int N_PASS       = 40;
    localparam int MAX_RUN      = 7;
    localparam int GAP          = 12;
    localparam int N_SEL_RUNS   = 8;
    localparam int N_OOR        = 3;
    localparam int RUN_CYCLES   = MAX_RUN + GAP + 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 256 + 20 + N_RAND_OPS + SETTLE + N_PASS
                                  + RUN_CYCLES * (N_SEL_RUNS + N_OOR + 1) + 80 + 256;

    logic                    clk;
    logic                    IPIF_bus2ip_resetn;
    bus_data_t               bus2ip_data;
    reg_ce_t                 bus2ip_wrce;
    reg_ce_t                 bus2ip_rdce;
    bus_data_t               ip2bus_data;
    logic                    ip2bus_rdack;
    logic                    ip2bus_wrack;
    data_word_t [NUM_CH-1:0] ch_data;
    logic [NUM_CH-1:0]       ch_valid;
    data_word_t              out_data;
    logic                    out_valid;
    logic                    out_idle;

    // Reference model state
    out_sel_t      m_sel;
    idle_cnt_t     m_nidle;
    data_word_t    m_idle_word;
    out_sel_t      m_sel_copy;
    filler_state_t m_state;
    idle_cnt_t     m_cnt;
    data_word_t    m_mux_data;
    logic          m_mux_valid;
    data_word_t    m_out_data;
    logic          m_out_valid;
    logic          m_out_idle;
    bus_data_t     m_rdata;
    logic          m_rdack;
    logic          m_wrack;

    int       cycle_cnt = 0;
    out_sel_t cur_sel   = RST_OUTPUT_SELECT;

    task automatic abort_run();
    begin
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    end
    endtask

    `include "tb_checks.svh"

    stream_output_top u_stream_output_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            abort_run();
        end
    end

    // Channel traffic runs freely during the whole test
    always @(posedge clk)
    begin
        for (int i = 0; i < NUM_CH; i++)
            ch_data[i] <= $urandom;
        ch_valid <= NUM_CH'($urandom);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model stepping once per rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!IPIF_bus2ip_resetn)
        begin
            m_sel       = RST_OUTPUT_SELECT;
            m_nidle     = RST_N_IDLE_WORDS;
            m_idle_word = RST_IDLE_WORD;
            m_sel_copy  = RST_OUTPUT_SELECT;
            m_state     = FILL;
            m_cnt       = RST_N_IDLE_WORDS;
            m_mux_data  = '0;
            m_mux_valid = 1'b0;
            m_out_data  = '0;
            m_out_valid = 1'b0;
            m_out_idle  = 1'b0;
            m_rdata     = '0;
            m_rdack     = 1'b0;
            m_wrack     = 1'b0;
        end
        else
        begin
            // Filler sees the mux register and settings from before this edge
            if (m_sel != m_sel_copy)
            begin
                m_sel_copy = m_sel;
                m_cnt      = m_nidle;
                m_state    = (m_nidle == '0) ? PASS : FILL;
            end
            if (m_state == FILL)
            begin
                m_out_valid = 1'b1;
                m_out_idle  = 1'b1;
                m_out_data  = m_idle_word;
                m_cnt       = m_cnt - 1'b1;
                if (m_cnt == '0)
                    m_state = PASS;
            end
            else
            begin
                m_out_valid = m_mux_valid;
                m_out_idle  = 1'b0;
                m_out_data  = m_mux_data;
            end

            m_mux_valid = (m_sel < NUM_CH) ? ch_valid[m_sel[1:0]] : 1'b0;
            m_mux_data  = ch_data[m_sel[1:0]];

            // Reads return the value before a write in the same cycle
            m_wrack = |bus2ip_wrce;
            m_rdack = |bus2ip_rdce;
            case (bus2ip_rdce)
                CE_SEL:   m_rdata = {28'd0, m_sel};
                CE_NIDLE: m_rdata = {16'd0, m_nidle};
                CE_IDLE:  m_rdata = m_idle_word;
                default:  m_rdata = '0;
            endcase
            case (bus2ip_wrce)
                CE_SEL:   m_sel = bus2ip_data[3:0];
                CE_NIDLE: m_nidle = bus2ip_data[15:0];
                CE_IDLE:  m_idle_word = bus2ip_data;
                default:  ;
            endcase
        end
    end

    // Outputs are compared in the middle of each cycle
    always @(negedge clk)
    begin
        check_bit("ip2bus_wrack", ip2bus_wrack, m_wrack);
        check_bit("ip2bus_rdack", ip2bus_rdack, m_rdack);
        check_bus("ip2bus_data", ip2bus_data, m_rdata);
        check_bit("out_valid", out_valid, m_out_valid);
        check_bit("out_idle", out_idle, m_out_idle);
        if (m_out_valid)
            check_word("out_data", out_data, m_out_data);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_cycle(input reg_ce_t wr, input reg_ce_t rd, input bus_data_t data);
    begin
        @(posedge clk);
        bus2ip_wrce <= wr;
        bus2ip_rdce <= rd;
        bus2ip_data <= data;
        if (wr == CE_SEL)
            cur_sel = data[3:0];
        @(posedge clk);
        bus2ip_wrce <= '0;
        bus2ip_rdce <= '0;
    end
    endtask

    task automatic read_expect(input reg_ce_t ce, input bus_data_t expected);
    begin
        bus_cycle('0, ce, '0);
        @(negedge clk);
        check_bit("ip2bus_rdack", ip2bus_rdack, 1'b1);
        check_bus("ip2bus_data", ip2bus_data, expected);
    end
    endtask

    // Counts consecutive idle words of the next run
    task automatic measure_idle_run(input idle_cnt_t expected);
        idle_cnt_t seen;
    begin
        seen = '0;
        @(negedge clk);
        while (!out_idle)
            @(negedge clk);
        while (out_idle)
        begin
            seen = seen + 1'b1;
            @(negedge clk);
        end
        check_count("idle run length", seen, expected);
    end
    endtask

    task automatic run_select_change(input idle_cnt_t count, input out_sel_t sel);
    begin
        bus_cycle(CE_NIDLE, '0, bus_data_t'(count));
        bus_cycle(CE_SEL, '0, bus_data_t'(sel));
        if (count != '0)
            measure_idle_run(count);
    end
    endtask

    function automatic out_sel_t pick_channel();
        int unsigned step;
    begin
        step = $urandom_range(1, NUM_CH - 1);
        return out_sel_t'((cur_sel[1:0] + step) % NUM_CH);
    end
    endfunction

    function automatic out_sel_t pick_out_of_range();
        int unsigned step;
    begin
        step = $urandom_range(1, N_OOR_SEL - 1);
        return out_sel_t'(NUM_CH + (int'(cur_sel) + N_OOR_SEL - NUM_CH + step) % N_OOR_SEL);
    end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int unsigned seed_ret;
        reg_ce_t     wr;
        bus_data_t   data;

        seed_ret           = $urandom(SEED);
        clk                = 1'b0;
        IPIF_bus2ip_resetn = 1'b0;
        bus2ip_data        = '0;
        bus2ip_wrce        = '0;
        bus2ip_rdce        = '0;
        ch_data            = '0;
        ch_valid           = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        IPIF_bus2ip_resetn <= 1'b1;

        // Startup run, then the reset values
        measure_idle_run(idle_cnt_t'(256));
        read_expect(CE_SEL, 32'd0);
        read_expect(CE_NIDLE, 32'd256);
        read_expect(CE_IDLE, 32'haccccccc);

        // Random register traffic with short runs
        bus_cycle(CE_NIDLE, '0, 32'd4);
        for (int i = 0; i < N_RAND_OPS; i++)
        begin
            @(posedge clk);
            wr   = reg_ce_t'($urandom);
            data = $urandom;
            if (wr == CE_NIDLE)
                data[15:4] = '0;
            if (wr == CE_SEL)
                cur_sel = data[3:0];
            bus2ip_wrce <= wr;
            bus2ip_rdce <= reg_ce_t'($urandom);
            bus2ip_data <= data;
        end
        @(posedge clk);
        bus2ip_wrce <= '0;
        bus2ip_rdce <= '0;
        repeat (SETTLE) @(posedge clk);

        // Pass-through on a fixed channel
        run_select_change(idle_cnt_t'(3), pick_channel());
        repeat (N_PASS) @(posedge clk);

        // Select changes with small counts including zero
        for (int i = 0; i < N_SEL_RUNS; i++)
        begin
            bus_cycle(CE_IDLE, '0, $urandom);
            run_select_change(idle_cnt_t'($urandom_range(0, MAX_RUN)), pick_channel());
            repeat (GAP) @(posedge clk);
        end

        // Out-of-range selects go quiet after the run
        for (int i = 0; i < N_OOR; i++)
        begin
            run_select_change(idle_cnt_t'($urandom_range(1, MAX_RUN)), pick_out_of_range());
            repeat (GAP)
            begin
                check_bit("out_valid", out_valid, 1'b0);
                @(negedge clk);
            end
        end

        // Count write during a run waits, select rewrite restarts it
        bus_cycle(CE_NIDLE, '0, 32'd20);
        bus_cycle(CE_SEL, '0, bus_data_t'(pick_channel()));
        repeat (3) @(posedge clk);
        bus_cycle(CE_NIDLE, '0, 32'd5);
        repeat (5) @(posedge clk);
        bus_cycle(CE_SEL, '0, bus_data_t'(pick_channel()));
        repeat (40) @(posedge clk);

        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+tests
verilog/ipif_pkg.sv
verilog/stream_pkg.sv
verilog/ipif_param_decode.sv
verilog/channel_mux.sv
verilog/idle_filler.sv
verilog/stream_output_top.sv
tests/tb_stream_output.sv
